// ==== logic/adma_pkg.sv ====
package adma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and descriptor types
  ////////////////////////////////////////////////////////////////////////////

  // System memory byte address
  typedef logic [31:0] addr_t;

  // One AXI read data beat
  typedef logic [31:0] word_t;

  // One ADMA2 descriptor line, low word first in memory
  typedef logic [63:0] desc_t;

  // Field positions inside desc_t
  localparam int VALID_BIT = 0;
  localparam int END_BIT   = 1;
  localparam int ACT_LSB   = 4;
  localparam int LEN_LSB   = 16;
  localparam int ADDR_LSB  = 32;

  // Action codes, bits 5..4 of the line
  localparam logic [1:0] ACT_NOP  = 2'b00;
  localparam logic [1:0] ACT_TRAN = 2'b10;
  localparam logic [1:0] ACT_LINK = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // Stepping and burst constants
  ////////////////////////////////////////////////////////////////////////////

  // Next descriptor line sits 8 bytes further on
  localparam logic [31:0] DESC_STEP = 32'd8;

  // Longest read burst and its address step
  localparam logic [4:0]  BURST_WORDS = 5'd16;
  localparam logic [31:0] BURST_BYTES = 32'd64;

  // Word count width, a zero length gives 16384 words
  localparam int LEN_W = 15;

  // Descriptor machine states
  typedef enum logic [1:0] {
    st_stop,
    st_fds,
    st_cadr,
    st_tfr
  } adma_state_t;

endpackage

// ==== logic/adma_desc_regs.sv ====
module adma_desc_regs (
  input  logic             clock,
  input  logic             reset,
  input  adma_pkg::addr_t  descriptor_base,
  input  logic             load_base,
  input  logic             step_pointer,
  input  logic             link_pointer,
  input  adma_pkg::word_t  desc_beat,
  input  logic             desc_beat_valid,
  input  logic             set_complete,
  input  logic             set_invalid,
  input  logic             int_clear,
  output adma_pkg::addr_t  pointer,
  output adma_pkg::desc_t  desc,
  output logic [1:0]       interrupts
);

  import adma_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor table pointer
  ////////////////////////////////////////////////////////////////////////////

  // Only one command arrives per cycle from the machine
  always_ff @(posedge clock) begin
    if (load_base) begin
      pointer <= descriptor_base;
    end else if (link_pointer) begin
      // Jump to the table named by the link line
      pointer <= desc[ADDR_LSB +: 32];
    end else if (step_pointer) begin
      pointer <= pointer + DESC_STEP;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Current descriptor line
  ////////////////////////////////////////////////////////////////////////////

  // Beats shift in from the top, so after two beats
  // the first one sits in 31..0 and the second in 63..32
  always_ff @(posedge clock) begin
    if (desc_beat_valid) begin
      desc <= {desc_beat, desc[63:32]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sticky interrupt status
  ////////////////////////////////////////////////////////////////////////////

  // Bit 0 transfer complete, bit 1 invalid descriptor
  always_ff @(posedge clock) begin
    if (!reset) begin
      interrupts <= 2'b00;
    end else if (int_clear) begin
      // Clear wins over a set in the same cycle
      interrupts <= 2'b00;
    end else begin
      if (set_complete) begin
        interrupts[0] <= 1'b1;
      end
      if (set_invalid) begin
        interrupts[1] <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/adma_fsm.sv ====
module adma_fsm (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        dma_enable,
  input  logic                        data_present,
  input  logic                        cmd_complete,
  input  adma_pkg::addr_t             pointer,
  input  adma_pkg::desc_t             desc,
  input  logic                        req_done,
  output logic                        active,
  output logic                        req_start,
  output adma_pkg::addr_t             req_addr,
  output logic [adma_pkg::LEN_W-1:0]  req_words,
  output logic                        req_is_desc,
  output logic                        load_base,
  output logic                        step_pointer,
  output logic                        link_pointer,
  output logic                        set_complete,
  output logic                        set_invalid
);

  import adma_pkg::*;

  adma_state_t        state;
  adma_state_t        state_next;
  logic               start_cond;
  logic               issue;
  logic [1:0]         action;
  logic               desc_end;
  logic [15:0]        desc_len;
  logic [LEN_W-1:0]   tran_words;

  assign start_cond = dma_enable & data_present & cmd_complete;

  // Fields of the line held in the register block
  assign action   = desc[ACT_LSB +: 2];
  assign desc_end = desc[END_BIT];
  assign desc_len = desc[LEN_LSB +: 16];

  // Byte length to words, zero stands for 65536 bytes
  assign tran_words = (desc_len == 16'd0) ? LEN_W'(16384) : LEN_W'(desc_len[15:2]);

  assign active = (state != st_stop);

  ////////////////////////////////////////////////////////////////////////////
  // Read request to the engine
  ////////////////////////////////////////////////////////////////////////////

  // Request fields follow the state, the pointer has already settled
  // by the time the registered start pulse goes out
  assign req_is_desc = (state == st_fds);
  assign req_addr    = req_is_desc ? pointer : desc[ADDR_LSB +: 32];
  assign req_words   = req_is_desc ? LEN_W'(2) : tran_words;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and command pulses
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next   = state;
    issue        = 1'b0;
    load_base    = 1'b0;
    step_pointer = 1'b0;
    link_pointer = 1'b0;
    set_complete = 1'b0;
    set_invalid  = 1'b0;
    case (state)
      st_stop: begin
        if (start_cond) begin
          load_base  = 1'b1;
          issue      = 1'b1;
          state_next = st_fds;
        end
      end
      st_fds: begin
        if (req_done) begin
          if (!desc[VALID_BIT]) begin
            set_invalid = 1'b1;
            state_next  = st_stop;
          end else begin
            state_next = st_cadr;
          end
        end
      end
      st_cadr: begin
        // Always one cycle here
        if (action == ACT_LINK) begin
          link_pointer = 1'b1;
        end else begin
          step_pointer = 1'b1;
        end
        if (action == ACT_TRAN) begin
          issue      = 1'b1;
          state_next = st_tfr;
        end else if (desc_end && (action == ACT_NOP || action == ACT_LINK)) begin
          set_complete = 1'b1;
          state_next   = st_stop;
        end else begin
          issue      = 1'b1;
          state_next = st_fds;
        end
      end
      st_tfr: begin
        if (req_done) begin
          if (desc_end) begin
            set_complete = 1'b1;
            state_next   = st_stop;
          end else begin
            issue      = 1'b1;
            state_next = st_fds;
          end
        end
      end
      default: state_next = st_stop;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state     <= st_stop;
      req_start <= 1'b0;
    end else begin
      state     <= state_next;
      // Pulse on the first cycle of the new fetch or transfer
      req_start <= issue;
    end
  end

endmodule

// ==== logic/adma_read_engine.sv ====
module adma_read_engine (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        req_start,
  input  adma_pkg::addr_t             req_addr,
  input  logic [adma_pkg::LEN_W-1:0]  req_words,
  input  logic                        req_is_desc,
  input  logic                        ar_ready,
  input  logic                        r_valid,
  input  adma_pkg::word_t             r_data,
  input  logic                        r_last,
  output logic                        ar_valid,
  output adma_pkg::addr_t             ar_addr,
  output logic [7:0]                  ar_len,
  output logic                        r_ready,
  output adma_pkg::word_t             desc_beat,
  output logic                        desc_beat_valid,
  output adma_pkg::word_t             card_data,
  output logic                        card_write,
  output logic                        req_done
);

  import adma_pkg::*;

  addr_t             burst_addr;
  logic [LEN_W-1:0]  words_left;
  logic [4:0]        burst_words;
  logic              is_desc;
  logic              beat;

  // Smaller of a full burst and what is left
  assign burst_words = (words_left >= LEN_W'(BURST_WORDS)) ? BURST_WORDS
                                                           : words_left[4:0];

  // Both come from registers that only move outside the address phase
  assign ar_addr = burst_addr;
  assign ar_len  = {3'b000, burst_words - 5'd1};

  ////////////////////////////////////////////////////////////////////////////
  // Beat routing
  ////////////////////////////////////////////////////////////////////////////

  assign beat = r_valid & r_ready;

  assign desc_beat       = r_data;
  assign desc_beat_valid = beat & is_desc;
  assign card_data       = r_data;
  assign card_write      = beat & ~is_desc;

  ////////////////////////////////////////////////////////////////////////////
  // Burst sequencing, one burst in flight
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (req_start) begin
      burst_addr <= req_addr;
      is_desc    <= req_is_desc;
    end else if (ar_valid && ar_ready) begin
      burst_addr <= burst_addr + BURST_BYTES;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ar_valid   <= 1'b0;
      r_ready    <= 1'b0;
      req_done   <= 1'b0;
      words_left <= '0;
    end else begin
      req_done <= 1'b0;
      if (req_start) begin
        words_left <= req_words;
        // Nothing to read closes the request straight away
        ar_valid   <= (req_words != '0);
        req_done   <= (req_words == '0);
      end else if (ar_valid && ar_ready) begin
        ar_valid <= 1'b0;
        r_ready  <= 1'b1;
      end else if (beat) begin
        words_left <= words_left - LEN_W'(1);
        if (r_last) begin
          r_ready <= 1'b0;
          if (words_left == LEN_W'(1)) begin
            req_done <= 1'b1;
          end else begin
            ar_valid <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== logic/adma_top.sv ====
module adma_top (
  input  logic             clock,
  input  logic             reset,
  input  logic             dma_enable,
  input  logic             data_present,
  input  logic             cmd_complete,
  input  logic             int_clear,
  input  adma_pkg::addr_t  descriptor_base,
  input  logic             ar_ready,
  input  logic             r_valid,
  input  adma_pkg::word_t  r_data,
  input  logic             r_last,
  output logic [1:0]       interrupts,
  output logic             active,
  output adma_pkg::word_t  card_data,
  output logic             card_write,
  output logic             ar_valid,
  output adma_pkg::addr_t  ar_addr,
  output logic [7:0]       ar_len,
  output logic             r_ready
);

  import adma_pkg::*;

  // Machine to read engine
  logic              req_start;
  addr_t             req_addr;
  logic [LEN_W-1:0]  req_words;
  logic              req_is_desc;
  logic              req_done;
  word_t             desc_beat;
  logic              desc_beat_valid;

  // Machine to register block
  logic              load_base;
  logic              step_pointer;
  logic              link_pointer;
  logic              set_complete;
  logic              set_invalid;
  addr_t             pointer;
  desc_t             desc;

  adma_desc_regs u_desc_regs (
    .clock           (clock),
    .reset           (reset),
    .descriptor_base (descriptor_base),
    .load_base       (load_base),
    .step_pointer    (step_pointer),
    .link_pointer    (link_pointer),
    .desc_beat       (desc_beat),
    .desc_beat_valid (desc_beat_valid),
    .set_complete    (set_complete),
    .set_invalid     (set_invalid),
    .int_clear       (int_clear),
    .pointer         (pointer),
    .desc            (desc),
    .interrupts      (interrupts)
  );

  adma_fsm u_fsm (
    .clock        (clock),
    .reset        (reset),
    .dma_enable   (dma_enable),
    .data_present (data_present),
    .cmd_complete (cmd_complete),
    .pointer      (pointer),
    .desc         (desc),
    .req_done     (req_done),
    .active       (active),
    .req_start    (req_start),
    .req_addr     (req_addr),
    .req_words    (req_words),
    .req_is_desc  (req_is_desc),
    .load_base    (load_base),
    .step_pointer (step_pointer),
    .link_pointer (link_pointer),
    .set_complete (set_complete),
    .set_invalid  (set_invalid)
  );

  adma_read_engine u_read_engine (
    .clock           (clock),
    .reset           (reset),
    .req_start       (req_start),
    .req_addr        (req_addr),
    .req_words       (req_words),
    .req_is_desc     (req_is_desc),
    .ar_ready        (ar_ready),
    .r_valid         (r_valid),
    .r_data          (r_data),
    .r_last          (r_last),
    .ar_valid        (ar_valid),
    .ar_addr         (ar_addr),
    .ar_len          (ar_len),
    .r_ready         (r_ready),
    .desc_beat       (desc_beat),
    .desc_beat_valid (desc_beat_valid),
    .card_data       (card_data),
    .card_write      (card_write),
    .req_done        (req_done)
  );

endmodule

// ==== dv/adma_asserts.sv ====
module adma_asserts (
  input  logic             clock,
  input  logic             reset,
  input  logic             int_clear,
  input  logic [1:0]       interrupts,
  input  logic             active,
  input  adma_pkg::word_t  card_data,
  input  logic             card_write,
  input  logic             ar_valid,
  input  logic             ar_ready,
  input  adma_pkg::addr_t  ar_addr,
  input  logic [7:0]       ar_len,
  input  logic             r_ready,
  input  logic             req_is_desc
);

  import adma_pkg::*;

  // Chain run data of 32 words then 50
  localparam int CHAIN_WORDS = 82;

  bit           failed = 1'b0;
  int unsigned  strobes;
  logic         active_q;
  word_t        next_data;

  task automatic raise_error(input string msg);
    $error("%s", msg);
    failed = 1'b1;
  endtask

  // Strobes since the run began, and the address the next data word carries
  always_ff @(posedge clock) begin
    if (!reset) begin
      strobes   <= 0;
      active_q  <= 1'b0;
      next_data <= '0;
    end else begin
      active_q <= active;
      if (active && !active_q) begin
        strobes <= 0;
      end else if (card_write) begin
        strobes <= strobes + 1;
      end
      if (ar_valid && ar_ready) begin
        next_data <= ar_addr;
      end else if (card_write) begin
        next_data <= next_data + 32'd4;
      end
    end
  end

  a_ar_hold: assert property (@(posedge clock) disable iff (!reset)
    ar_valid && !ar_ready |=> $stable(ar_addr) && $stable(ar_len))
    else raise_error($sformatf("MISMATCH %0t ar_addr/ar_len held %h/%h now %h/%h", $time,
                               $past(ar_addr), $past(ar_len), $sampled(ar_addr),
                               $sampled(ar_len)));

  a_ar_len_max: assert property (@(posedge clock) disable iff (!reset)
    ar_valid |-> ar_len <= 8'd15)
    else raise_error($sformatf("MISMATCH %0t ar_len limit 0f got %h", $time, $sampled(ar_len)));

  a_card_data: assert property (@(posedge clock) disable iff (!reset)
    card_write |-> card_data == next_data)
    else raise_error($sformatf("MISMATCH %0t card_data expected %h got %h", $time,
                               $sampled(next_data), $sampled(card_data)));

  a_no_desc_data: assert property (@(posedge clock) disable iff (!reset)
    card_write |-> !req_is_desc)
    else raise_error("A descriptor word was written to the card FIFO");

  a_chain_count: assert property (@(posedge clock) disable iff (!reset)
    $rose(interrupts[0]) |-> strobes == CHAIN_WORDS)
    else raise_error($sformatf("MISMATCH %0t card_write count expected %0d got %0d", $time,
                               CHAIN_WORDS, $sampled(strobes)));

  a_invalid_count: assert property (@(posedge clock) disable iff (!reset)
    $rose(interrupts[1]) |-> strobes == 0)
    else raise_error($sformatf("MISMATCH %0t card_write count expected 0 got %0d", $time,
                               $sampled(strobes)));

  a_run_end: assert property (@(posedge clock) disable iff (!reset)
    $rose(interrupts[0]) || $rose(interrupts[1]) |-> $fell(active) && interrupts != 2'b11)
    else raise_error("Run ended without active falling, or with both interrupt bits set");

  a_reset_low: assert property (@(posedge clock)
    !reset |=> interrupts == 2'b00 && !active && !ar_valid && !r_ready && !card_write)
    else raise_error("Outputs were not low after reset");

  a_clear: assert property (@(posedge clock) disable iff (!reset)
    int_clear |=> interrupts == 2'b00)
    else raise_error($sformatf("MISMATCH %0t interrupts expected 0 got %b", $time,
                               $sampled(interrupts)));

endmodule

bind adma_top adma_asserts u_asserts (.*);

// ==== dv/adma_tb.sv ====
module adma_tb;

  import adma_pkg::*;

  // Descriptor and data words fetched over both runs (8 + 82 + 2)
  localparam int TOTAL_WORDS     = 92;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

  logic         clock;
  logic         reset;
  logic         dma_enable;
  logic         data_present;
  logic         cmd_complete;
  logic         int_clear;
  addr_t        descriptor_base;
  logic         ar_ready;
  logic         r_valid;
  word_t        r_data;
  logic         r_last;
  logic [1:0]   interrupts;
  logic         active;
  word_t        card_data;
  logic         card_write;
  logic         ar_valid;
  addr_t        ar_addr;
  logic [7:0]   ar_len;
  logic         r_ready;

  logic [15:0]  lfsr_state = 16'd48336;
  logic [63:0]  desc_table [addr_t];

  adma_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic random_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  // Valid in bit 0, end in bit 1, action in 5..4, length 31..16, address 63..32
  function automatic logic [63:0] desc_line(input logic valid, input logic last,
                                            input logic [1:0] act, input logic [15:0] len,
                                            input logic [31:0] addr);
    return {addr, len, 10'd0, act, 2'b00, last, valid};
  endfunction

  // Table words where a line exists, otherwise the word's own byte address
  function automatic word_t memory_word(input addr_t addr);
    addr_t line_addr;
    line_addr = {addr[31:3], 3'b000};
    if (desc_table.exists(line_addr)) begin
      return addr[2] ? desc_table[line_addr][63:32] : desc_table[line_addr][31:0];
    end
    return addr;
  endfunction

  task automatic report_failure(input string reason);
    $display("Some tests failed");
    $fatal(1, "%s", reason);
  endtask

  // Raise the start condition until the engine goes active, then wait for an interrupt
  task automatic start_run(input addr_t base);
    descriptor_base = base;
    dma_enable      = 1'b1;
    data_present    = 1'b1;
    cmd_complete    = 1'b1;
    @(negedge clock);
    while (!active) @(negedge clock);
    dma_enable   = 1'b0;
    data_present = 1'b0;
    cmd_complete = 1'b0;
    while (interrupts == 2'b00) @(negedge clock);
  endtask

  task automatic clear_interrupts();
    int_clear = 1'b1;
    @(negedge clock);
    int_clear = 1'b0;
    @(negedge clock);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI read slave with random address and beat delays
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    addr_t  burst_addr;
    int     burst_len;
    ar_ready = 1'b0;
    r_valid  = 1'b0;
    r_data   = '0;
    r_last   = 1'b0;
    @(negedge clock);
    while (reset !== 1'b1) @(negedge clock);
    forever begin
      while (!ar_valid) @(negedge clock);
      while (random_bit()) @(negedge clock);
      ar_ready   = 1'b1;
      burst_addr = ar_addr;
      burst_len  = ar_len;
      @(negedge clock);
      ar_ready = 1'b0;
      for (int i = 0; i <= burst_len; i++) begin
        r_valid = 1'b0;
        while (random_bit()) @(negedge clock);
        r_valid = 1'b1;
        r_data  = memory_word(burst_addr + 4 * i);
        r_last  = (i == burst_len);
        @(negedge clock);
      end
      r_valid = 1'b0;
      r_last  = 1'b0;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    report_failure("Timeout, the DMA runs did not finish");
  end

  initial begin
    wait (uut.u_asserts.failed);
    report_failure("An assertion on the DUT failed");
  end

  initial begin
    reset           = 1'b0;
    dma_enable      = 1'b0;
    data_present    = 1'b0;
    cmd_complete    = 1'b0;
    int_clear       = 1'b0;
    descriptor_base = '0;
    // Chain of tran 128, nop, link to 0x1100 and tran 200 with end
    desc_table[32'h1000] = desc_line(1'b1, 1'b0, 2'b10, 16'd128, 32'h2000);
    desc_table[32'h1008] = desc_line(1'b1, 1'b0, 2'b00, 16'd0, 32'h0);
    desc_table[32'h1010] = desc_line(1'b1, 1'b0, 2'b11, 16'd0, 32'h1100);
    desc_table[32'h1100] = desc_line(1'b1, 1'b1, 2'b10, 16'd200, 32'h3000);
    // Second table opens on a line with valid clear
    desc_table[32'h1200] = desc_line(1'b0, 1'b0, 2'b10, 16'd64, 32'h4000);
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    @(negedge clock);
    start_run(32'h1000);
    clear_interrupts();
    start_run(32'h1200);
    clear_interrupts();
    repeat (4) @(negedge clock);
    if (uut.u_asserts.failed) begin
      report_failure("An assertion on the DUT failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// ==== adma_top.f ====
logic/adma_pkg.sv
logic/adma_desc_regs.sv
logic/adma_fsm.sv
logic/adma_read_engine.sv
logic/adma_top.sv
dv/adma_asserts.sv
dv/adma_tb.sv

// ==== Bender.yml ====
package:
  name: adma

sources:
  - logic/adma_pkg.sv
  - logic/adma_desc_regs.sv
  - logic/adma_fsm.sv
  - logic/adma_read_engine.sv
  - logic/adma_top.sv
  - target: test
    files:
      - dv/adma_asserts.sv
      - dv/adma_tb.sv
